// File: src/sampleFormatPkg.sv
package sampleFormatPkg;

    //////////////////////////////////////////////////////////////////////
    // Datapath widths
    //////////////////////////////////////////////////////////////////////

    // Input samples, two's complement
    localparam int SampleWidth = 15;
    localparam int CoefWidth = 17;

    // Pre-add grows one bit, then times coefficient
    localparam int ProductWidth = 33;

    // One guard bit over a single product
    localparam int AccWidth = 34;
    localparam int OutWidth = 14;

    //////////////////////////////////////////////////////////////////////
    // Rounding and saturation
    //////////////////////////////////////////////////////////////////////

    // LSBs dropped on the way to the output
    localparam int RoundShift = 17;

    // Half an output LSB, and one less for negative sums
    localparam logic signed [AccWidth-1:0] RoundHalf = 1 <<< (RoundShift - 1);
    localparam logic signed [AccWidth-1:0] RoundHalfNeg = RoundHalf - 1;

    // Output sign bit position inside the accumulator
    localparam int SatGuardLsb = RoundShift + OutWidth - 1;

    // Saturation limits
    localparam logic signed [OutWidth-1:0] OutMax = 14'h1FFF;
    localparam logic signed [OutWidth-1:0] OutMin = 14'h2000;

endpackage

// File: src/filterCoefPkg.sv
package filterCoefPkg;

    //////////////////////////////////////////////////////////////////////
    // Half-band response shape
    //////////////////////////////////////////////////////////////////////

    // Per-channel filter length
    localparam int NumTaps = 47;

    // Non-zero symmetric pairs, odd taps other than center are zero
    localparam int NumPairs = 12;

    // Center tap position, the only non-zero odd tap
    localparam int CenterTap = 23;

    //////////////////////////////////////////////////////////////////////
    // Coefficients, Q16
    //////////////////////////////////////////////////////////////////////

    // Entry p serves taps 2p and NumTaps-1-2p
    localparam logic signed [sampleFormatPkg::CoefWidth-1:0] CoefTable [NumPairs] = '{
        -17'sd8,
        17'sd27,
        -17'sd68,
        17'sd146,
        -17'sd281,
        17'sd499,
        -17'sd837,
        17'sd1353,
        -17'sd2161,
        17'sd3547,
        -17'sd6561,
        17'sd20727
    };

    // 0.5 in Q16, still positive in 17 bits
    localparam logic signed [sampleFormatPkg::CoefWidth-1:0] CenterCoef = 17'sd32768;

endpackage

// File: src/channelInterleaver.sv
`timescale 1ns/10ps

module channelInterleaver
(
    input  logic                                        Clk,
    input  logic                                        Reset,
    input  logic signed [sampleFormatPkg::SampleWidth-1:0] DataIn0,
    input  logic signed [sampleFormatPkg::SampleWidth-1:0] DataIn1,
    input  logic                                        Index,
    output logic signed [sampleFormatPkg::SampleWidth-1:0] Sample,
    output logic                                        SampleChannel,
    output logic                                        KeepPhase
);

    // Decimation phase, low means drop
    logic phase;

    //////////////////////////////////////////////////////////////////////
    // Channel select and tag
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk or posedge Reset)
    begin
        if (Reset)
        begin
            Sample        <= '0;
            SampleChannel <= 1'b0;
            KeepPhase     <= 1'b0;
        end
        else
        begin
            // Index high picks channel 0
            Sample        <= Index ? DataIn0 : DataIn1;
            SampleChannel <= ~Index;
            // Phase as seen before this edge, same for both halves of a pair
            KeepPhase     <= phase;
        end
    end

    // Flip after every channel 1 sample, so every second pair is kept
    always_ff @(posedge Clk or posedge Reset)
    begin
        if (Reset)
            phase <= 1'b0;
        else if (!Index)
            phase <= ~phase;
    end

endmodule

// File: src/tapDelayLine.sv
`timescale 1ns/10ps

module tapDelayLine
#(
    parameter int Depth = 94
)
(
    input  logic                                        Clk,
    input  logic                                        Reset,
    input  logic signed [sampleFormatPkg::SampleWidth-1:0] Sample,
    output logic signed [sampleFormatPkg::SampleWidth-1:0] Taps [Depth]
);

    //////////////////////////////////////////////////////////////////////
    // Interleaved sample history
    //////////////////////////////////////////////////////////////////////

    // Channels alternate slot by slot
    // Same channel's previous sample sits NumChannels slots further down
    always_ff @(posedge Clk or posedge Reset)
    begin
        if (Reset)
        begin
            for (int i = 0; i < Depth; i++)
            begin
                Taps[i] <= '0;
            end
        end
        else
        begin
            // Newest sample enters at slot 0
            Taps[0] <= Sample;
            // Everything else moves one slot on
            for (int i = 1; i < Depth; i++)
            begin
                Taps[i] <= Taps[i-1];
            end
        end
    end

endmodule

// File: src/symmetricMacSlice.sv
`timescale 1ns/10ps

module symmetricMacSlice
(
    input  logic                                         Clk,
    input  logic                                         Reset,
    input  logic signed [sampleFormatPkg::SampleWidth-1:0]  TapA,
    input  logic signed [sampleFormatPkg::SampleWidth-1:0]  TapD,
    input  logic signed [sampleFormatPkg::CoefWidth-1:0]    Coef,
    output logic signed [sampleFormatPkg::ProductWidth-1:0] Product
);

    // One bit wider than a sample, pair sum cannot wrap
    logic signed [sampleFormatPkg::SampleWidth:0] preSum;

    //////////////////////////////////////////////////////////////////////
    // Stage 1, pre-adder
    //////////////////////////////////////////////////////////////////////

    // Both taps share one coefficient
    always_ff @(posedge Clk or posedge Reset)
    begin
        if (Reset)
            preSum <= '0;
        else
            preSum <= TapA + TapD;
    end

    //////////////////////////////////////////////////////////////////////
    // Stage 2, multiplier
    //////////////////////////////////////////////////////////////////////

    // Signed 16 x 17, full 33-bit product
    always_ff @(posedge Clk or posedge Reset)
    begin
        if (Reset)
            Product <= '0;
        else
            Product <= preSum * Coef;
    end

endmodule

// File: src/halfBandCore.sv
`timescale 1ns/10ps

module halfBandCore
#(
    parameter int NumChannels = 2
)
(
    input  logic                                        Clk,
    input  logic                                        Reset,
    input  logic signed [sampleFormatPkg::SampleWidth-1:0] Sample,
    input  logic                                        SampleChannel,
    input  logic                                        KeepPhase,
    output logic signed [sampleFormatPkg::AccWidth-1:0]    SumValue,
    output logic                                        SumChannel,
    output logic                                        SumKeep
);

    // Enough slots for the whole response of every channel
    localparam int Depth = filterCoefPkg::NumTaps * NumChannels;

    // Slot 0 load, pre-add, product, sum
    localparam int TagDepth = 4;

    // Center tap slot
    localparam int CenterSlot = filterCoefPkg::CenterTap * NumChannels;

    logic signed [sampleFormatPkg::SampleWidth-1:0]  taps [Depth];
    logic signed [sampleFormatPkg::ProductWidth-1:0] products [filterCoefPkg::NumPairs];
    // Center tap held two cycles to meet the products
    logic signed [sampleFormatPkg::SampleWidth-1:0]  centerDly [2];
    logic signed [sampleFormatPkg::AccWidth-1:0]     sumNext;
    logic [TagDepth-1:0]                             channelPipe;
    logic [TagDepth-1:0]                             keepPipe;

    //////////////////////////////////////////////////////////////////////
    // Sample history and symmetric pairs
    //////////////////////////////////////////////////////////////////////

    tapDelayLine
    #(
        .Depth (Depth)
    )
    tapDelayLine_inst
    (
        .Clk    (Clk),
        .Reset  (Reset),
        .Sample (Sample),
        .Taps   (taps)
    );

    // Pair p joins taps 2p and NumTaps-1-2p of the same channel
    for (genvar p = 0; p < filterCoefPkg::NumPairs; p++)
    begin : gPair
        symmetricMacSlice symmetricMacSlice_inst
        (
            .Clk     (Clk),
            .Reset   (Reset),
            .TapA    (taps[2 * p * NumChannels]),
            .TapD    (taps[(filterCoefPkg::NumTaps - 1 - 2 * p) * NumChannels]),
            .Coef    (filterCoefPkg::CoefTable[p]),
            .Product (products[p])
        );
    end

    // Same two stages as a slice, no arithmetic
    always_ff @(posedge Clk or posedge Reset)
    begin
        if (Reset)
        begin
            centerDly[0] <= '0;
            centerDly[1] <= '0;
        end
        else
        begin
            centerDly[0] <= taps[CenterSlot];
            centerDly[1] <= centerDly[0];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Final sum
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        // Center term, 0.5 in Q16
        sumNext = centerDly[1] * filterCoefPkg::CenterCoef;
        for (int i = 0; i < filterCoefPkg::NumPairs; i++)
        begin
            sumNext = sumNext + products[i];
        end
    end

    always_ff @(posedge Clk or posedge Reset)
    begin
        if (Reset)
            SumValue <= '0;
        else
            SumValue <= sumNext;
    end

    // Tags walk alongside, one result per clock in flight per stage
    always_ff @(posedge Clk or posedge Reset)
    begin
        if (Reset)
        begin
            channelPipe <= '0;
            keepPipe    <= '0;
        end
        else
        begin
            channelPipe <= {channelPipe[TagDepth-2:0], SampleChannel};
            keepPipe    <= {keepPipe[TagDepth-2:0], KeepPhase};
        end
    end

    assign SumChannel = channelPipe[TagDepth-1];
    assign SumKeep    = keepPipe[TagDepth-1];

endmodule

// File: src/roundSaturate.sv
`timescale 1ns/10ps

module roundSaturate
#(
    parameter int NumChannels = 2
)
(
    input  logic                                     Clk,
    input  logic                                     Reset,
    input  logic signed [sampleFormatPkg::AccWidth-1:0] SumValue,
    input  logic                                     SumChannel,
    input  logic                                     SumKeep,
    output logic signed [sampleFormatPkg::OutWidth-1:0] DataOut0,
    output logic signed [sampleFormatPkg::OutWidth-1:0] DataOut1,
    output logic                                     Overflow0,
    output logic                                     Overflow1,
    output logic                                     OutValid0,
    output logic                                     OutValid1
);

    localparam int AccWidth = sampleFormatPkg::AccWidth;
    localparam int GuardLsb = sampleFormatPkg::SatGuardLsb;

    logic signed [AccWidth-1:0]                  rounded;
    // Sign bit of output plus bits above it
    logic [AccWidth-GuardLsb-1:0]                guardBits;
    logic                                        overflow;
    logic signed [sampleFormatPkg::OutWidth-1:0] satValue;
    logic signed [sampleFormatPkg::OutWidth-1:0] dataReg [NumChannels];
    logic [NumChannels-1:0]                      overflowReg;
    logic [NumChannels-1:0]                      validReg;

    //////////////////////////////////////////////////////////////////////
    // Rounding and saturation
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        // Symmetric rounding, ties go away from zero
        if (SumValue[AccWidth-1])
            rounded = SumValue + sampleFormatPkg::RoundHalfNeg;
        else
            rounded = SumValue + sampleFormatPkg::RoundHalf;
        guardBits = rounded[AccWidth-1:GuardLsb];
        // Fits only if all guard bits agree
        overflow = (guardBits != '0) && (guardBits != '1);
        if (!overflow)
            satValue = rounded[GuardLsb:sampleFormatPkg::RoundShift];
        else if (!rounded[AccWidth-1])
            satValue = sampleFormatPkg::OutMax;
        else
            satValue = sampleFormatPkg::OutMin;
    end

    // Only the tagged channel moves, the other holds
    always_ff @(posedge Clk or posedge Reset)
    begin
        if (Reset)
        begin
            for (int ch = 0; ch < NumChannels; ch++)
            begin
                dataReg[ch] <= '0;
            end
            overflowReg <= '0;
            validReg    <= '0;
        end
        else
        begin
            for (int ch = 0; ch < NumChannels; ch++)
            begin
                validReg[ch] <= SumKeep && (int'(SumChannel) == ch);
                if (SumKeep && (int'(SumChannel) == ch))
                begin
                    dataReg[ch]     <= satValue;
                    overflowReg[ch] <= overflow;
                end
            end
        end
    end

    // Per-channel ports
    assign DataOut0  = dataReg[0];
    assign DataOut1  = dataReg[1];
    assign Overflow0 = overflowReg[0];
    assign Overflow1 = overflowReg[1];
    assign OutValid0 = validReg[0];
    assign OutValid1 = validReg[1];

endmodule

// File: src/dualChannelHalfBand.sv
`timescale 1ns/10ps

module dualChannelHalfBand
#(
    parameter int NumChannels = 2
)
(
    input  logic                                        Clk,
    input  logic                                        Reset,
    input  logic signed [sampleFormatPkg::SampleWidth-1:0] DataIn0,
    input  logic signed [sampleFormatPkg::SampleWidth-1:0] DataIn1,
    input  logic                                        Index,
    output logic signed [sampleFormatPkg::OutWidth-1:0]    DataOut0,
    output logic signed [sampleFormatPkg::OutWidth-1:0]    DataOut1,
    output logic                                        Overflow0,
    output logic                                        Overflow1,
    output logic                                        OutValid0,
    output logic                                        OutValid1
);

    // Interleaver to core
    logic signed [sampleFormatPkg::SampleWidth-1:0] sample;
    logic                                           sampleChannel;
    logic                                           keepPhase;

    // Core to output stage
    logic signed [sampleFormatPkg::AccWidth-1:0]    sumValue;
    logic                                           sumChannel;
    logic                                           sumKeep;

    //////////////////////////////////////////////////////////////////////
    // Input, filter, output
    //////////////////////////////////////////////////////////////////////

    channelInterleaver channelInterleaver_inst
    (
        .Clk           (Clk),
        .Reset         (Reset),
        .DataIn0       (DataIn0),
        .DataIn1       (DataIn1),
        .Index         (Index),
        .Sample        (sample),
        .SampleChannel (sampleChannel),
        .KeepPhase     (keepPhase)
    );

    halfBandCore
    #(
        .NumChannels (NumChannels)
    )
    halfBandCore_inst
    (
        .Clk           (Clk),
        .Reset         (Reset),
        .Sample        (sample),
        .SampleChannel (sampleChannel),
        .KeepPhase     (keepPhase),
        .SumValue      (sumValue),
        .SumChannel    (sumChannel),
        .SumKeep       (sumKeep)
    );

    // Rounded, clipped and split per channel
    roundSaturate
    #(
        .NumChannels (NumChannels)
    )
    roundSaturate_inst
    (
        .Clk        (Clk),
        .Reset      (Reset),
        .SumValue   (sumValue),
        .SumChannel (sumChannel),
        .SumKeep    (sumKeep),
        .DataOut0   (DataOut0),
        .DataOut1   (DataOut1),
        .Overflow0  (Overflow0),
        .Overflow1  (Overflow1),
        .OutValid0  (OutValid0),
        .OutValid1  (OutValid1)
    );

endmodule

// File: test/roundSaturate_properties.sv
`timescale 1ns/10ps

module roundSaturateProperties
(
    input logic                                        Clk,
    input logic                                        Reset,
    input logic signed [sampleFormatPkg::OutWidth-1:0] DataOut0,
    input logic signed [sampleFormatPkg::OutWidth-1:0] DataOut1,
    input logic                                        Overflow0,
    input logic                                        Overflow1,
    input logic                                        OutValid0,
    input logic                                        OutValid1
);

    //////////////////////////////////////////////////////////////////////
    // Output stage rules
    //////////////////////////////////////////////////////////////////////

    // One channel per result slot
    validExclusive: assert property (@(posedge Clk) disable iff (Reset)
        !(OutValid0 && OutValid1))
        else $error("OutValid0 and OutValid1 high in the same cycle");

    // A flagged output sits on a rail
    overflowSaturated0: assert property (@(posedge Clk) disable iff (Reset)
        Overflow0 |-> (DataOut0 == sampleFormatPkg::OutMax || DataOut0 == sampleFormatPkg::OutMin))
        else $error("Overflow0 set while DataOut0 is not saturated");

    overflowSaturated1: assert property (@(posedge Clk) disable iff (Reset)
        Overflow1 |-> (DataOut1 == sampleFormatPkg::OutMax || DataOut1 == sampleFormatPkg::OutMin))
        else $error("Overflow1 set while DataOut1 is not saturated");

    // Strobes are single cycle
    validPulse0: assert property (@(posedge Clk) disable iff (Reset) OutValid0 |=> !OutValid0)
        else $error("OutValid0 held longer than one cycle");

    validPulse1: assert property (@(posedge Clk) disable iff (Reset) OutValid1 |=> !OutValid1)
        else $error("OutValid1 held longer than one cycle");

endmodule

// File: test/dualChannelHalfBandTb.sv
`timescale 1ns/10ps

module dualChannelHalfBandTb;

    localparam int ClkPeriod = 4;
    localparam int ResetCycles = 16;
    localparam int NumTaps = filterCoefPkg::NumTaps;
    localparam int NumRows = 6;
    // Zero pairs after the last row
    localparam int FlushPairs = 4;
    // Capture edge to valid strobe
    localparam int Latency = 5;
    localparam longint HalfLsb = longint'(1) << (sampleFormatPkg::RoundShift - 1);
    localparam longint OutMaxVal = longint'(sampleFormatPkg::OutMax);
    localparam longint OutMinVal = longint'(sampleFormatPkg::OutMin);

    typedef enum logic [1:0] {KindImpulse, KindStep, KindAlternate, KindRandom} kindT;

    typedef struct packed
    {
        kindT kind;
        int   amp0;
        int   amp1;
        int   pairs;
        logic overflowEnd;
    } rowT;

    //////////////////////////////////////////////////////////////////////
    // Stimulus table
    //////////////////////////////////////////////////////////////////////

    // Even lengths, every row ends on a kept pair
    // Random amplitudes stay below the level that could clip
    localparam rowT Rows [NumRows] = '{
        '{KindImpulse,   16383,      0, 48, 1'b0},
        '{KindStep,       6000,  -3000, 48, 1'b0},
        '{KindAlternate, 16383, -16383, 48, 1'b1},
        '{KindStep,        100,    -80, 48, 1'b0},
        '{KindRandom,    10000,   5000, 64, 1'b0},
        '{KindRandom,      500,  10000, 64, 1'b0}
    };

    logic                                           Clk = 1'b0;
    logic                                           Reset;
    logic signed [sampleFormatPkg::SampleWidth-1:0] DataIn0;
    logic signed [sampleFormatPkg::SampleWidth-1:0] DataIn1;
    logic                                           Index;
    logic signed [sampleFormatPkg::OutWidth-1:0]    DataOut0;
    logic signed [sampleFormatPkg::OutWidth-1:0]    DataOut1;
    logic                                           Overflow0;
    logic                                           Overflow1;
    logic                                           OutValid0;
    logic                                           OutValid1;

    // Reference model state, newest sample at index 0
    longint      coefFull [NumTaps];
    int          history [2][NumTaps];
    int          pairIndex;
    int          keptPairs;
    int          seed;
    int          cycle;
    int          checked0;
    int          checked1;
    logic        draining;
    logic        seenValid;
    // Entry is {rowEnd, rowFlag, overflow, data}
    logic [16:0] expWord0 [$];
    logic [16:0] expWord1 [$];
    int          expCycle0 [$];
    int          expCycle1 [$];

    dualChannelHalfBand dualChannelHalfBand_inst
    (
        .Clk       (Clk),
        .Reset     (Reset),
        .DataIn0   (DataIn0),
        .DataIn1   (DataIn1),
        .Index     (Index),
        .DataOut0  (DataOut0),
        .DataOut1  (DataOut1),
        .Overflow0 (Overflow0),
        .Overflow1 (Overflow1),
        .OutValid0 (OutValid0),
        .OutValid1 (OutValid1)
    );

    bind roundSaturate roundSaturateProperties roundSaturateProperties_inst
    (
        .Clk       (Clk),
        .Reset     (Reset),
        .DataOut0  (DataOut0),
        .DataOut1  (DataOut1),
        .Overflow0 (Overflow0),
        .Overflow1 (Overflow1),
        .OutValid0 (OutValid0),
        .OutValid1 (OutValid1)
    );

    always
    begin
        #(ClkPeriod / 2) Clk = ~Clk;
    end

    // Edges since reset release, edge 1 captures the first sample
    always @(posedge Clk)
    begin
        if (Reset)
            cycle <= 0;
        else
            cycle <= cycle + 1;
    end

    task automatic stopOnError(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected)
            stopOnError($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h",
                                  name, actual, expected));
    endtask

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    // {overflow, data} for the newest sample of one channel
    function automatic logic [14:0] referenceOutput(input int ch);
        longint acc;
        longint scaled;
        logic   over;
        acc = 0;
        for (int k = 0; k < NumTaps; k++)
        begin
            acc = acc + coefFull[k] * history[ch][k];
        end
        // Ties round away from zero
        acc = (acc < 0) ? acc + HalfLsb - 1 : acc + HalfLsb;
        scaled = acc >>> sampleFormatPkg::RoundShift;
        over = (scaled > OutMaxVal) || (scaled < OutMinVal);
        if (scaled > OutMaxVal)
            scaled = OutMaxVal;
        else if (scaled < OutMinVal)
            scaled = OutMinVal;
        return {over, scaled[13:0]};
    endfunction

    // Channel 0 with Index high, then channel 1
    task automatic drivePair(input int s0, input int s1);
        Index = 1'b1;
        DataIn0 = 15'(s0);
        DataIn1 = 15'(s1);
        @(negedge Clk);
        Index = 1'b0;
        @(negedge Clk);
    endtask

    task automatic applyPair(input int s0, input int s1, input logic rowEnd,
                             input logic rowFlag);
        for (int k = NumTaps - 1; k > 0; k--)
        begin
            history[0][k] = history[0][k-1];
            history[1][k] = history[1][k-1];
        end
        history[0][0] = s0;
        history[1][0] = s1;
        // Odd pairs since reset are kept
        if (pairIndex % 2 == 1)
        begin
            expWord0.push_back({rowEnd, rowFlag, referenceOutput(0)});
            expCycle0.push_back(2 * pairIndex + 1 + Latency);
            expWord1.push_back({rowEnd, rowFlag, referenceOutput(1)});
            expCycle1.push_back(2 * pairIndex + 2 + Latency);
            keptPairs++;
        end
        pairIndex++;
        drivePair(s0, s1);
    endtask

    task automatic applyRow(input rowT row);
        int s0;
        int s1;
        for (int j = 0; j < row.pairs; j++)
        begin
            case (row.kind)
                KindImpulse:
                begin
                    // Odd position, kept outputs walk the even taps
                    s0 = (j == 1) ? row.amp0 : 0;
                    s1 = (j == 1) ? row.amp1 : 0;
                end
                KindStep:
                begin
                    s0 = row.amp0;
                    s1 = row.amp1;
                end
                KindAlternate:
                begin
                    // Signs follow the taps, fully matched on the last pair
                    s0 = (coefFull[(j + NumTaps - 1) % NumTaps] < 0) ? -row.amp0 : row.amp0;
                    s1 = (coefFull[(j + NumTaps - 1) % NumTaps] < 0) ? -row.amp1 : row.amp1;
                end
                default:
                begin
                    s0 = $random(seed) % (row.amp0 + 1);
                    s1 = $random(seed) % (row.amp1 + 1);
                end
            endcase
            applyPair(s0, s1, j == row.pairs - 1, row.overflowEnd);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Output checker
    //////////////////////////////////////////////////////////////////////

    task automatic checkResult(input int ch);
        logic [16:0]                                 word;
        int                                          due;
        logic signed [sampleFormatPkg::OutWidth-1:0] data;
        logic                                        over;
        if ((ch == 0 ? expWord0.size() : expWord1.size()) == 0)
        begin
            // Drain pairs still strobe, nothing left to compare
            if (!draining)
                stopOnError($sformatf("Channel %0d strobed with no result pending", ch));
        end
        else
        begin
            word = (ch == 0) ? expWord0.pop_front() : expWord1.pop_front();
            due  = (ch == 0) ? expCycle0.pop_front() : expCycle1.pop_front();
            data = (ch == 0) ? DataOut0 : DataOut1;
            over = (ch == 0) ? Overflow0 : Overflow1;
            checkValue($sformatf("OutValid%0d cycle", ch), cycle, due);
            checkValue($sformatf("DataOut%0d", ch), {18'd0, data}, {18'd0, word[13:0]});
            checkValue($sformatf("Overflow%0d", ch), {31'd0, over}, {31'd0, word[14]});
            // Flag the table expects once a row is done
            if (word[16])
                checkValue($sformatf("Overflow%0d at row end", ch), {31'd0, over},
                           {31'd0, word[15]});
            if (ch == 0)
                checked0++;
            else
                checked1++;
        end
    endtask

    // Outputs are registered, stable at the falling edge
    always @(negedge Clk)
    begin
        if (cycle > 0)
        begin
            // Idle outputs up to the first kept result
            if (!seenValid && !OutValid0 && !OutValid1)
            begin
                checkValue("DataOut0", {18'd0, DataOut0}, 32'd0);
                checkValue("DataOut1", {18'd0, DataOut1}, 32'd0);
                checkValue("Overflow0", {31'd0, Overflow0}, 32'd0);
                checkValue("Overflow1", {31'd0, Overflow1}, 32'd0);
            end
            if (OutValid0 || OutValid1)
                seenValid = 1'b1;
            if (OutValid0)
                checkResult(0);
            if (OutValid1)
                checkResult(1);
        end
    end

    // Watchdog sized from the table
    initial
    begin
        int totalPairs;
        totalPairs = FlushPairs;
        for (int r = 0; r < NumRows; r++)
        begin
            totalPairs = totalPairs + Rows[r].pairs;
        end
        #((ResetCycles + 2 * totalPairs + 100) * ClkPeriod);
        stopOnError("Timeout: the filter did not deliver all results in time");
    end

    initial
    begin
        int drainCount;
        Reset     = 1'b1;
        Index     = 1'b0;
        DataIn0   = '0;
        DataIn1   = '0;
        seed      = 95985;
        pairIndex = 0;
        keptPairs = 0;
        checked0  = 0;
        checked1  = 0;
        draining  = 1'b0;
        seenValid = 1'b0;
        // Full 47-tap response, odd taps other than center stay zero
        for (int p = 0; p < filterCoefPkg::NumPairs; p++)
        begin
            coefFull[2 * p] = filterCoefPkg::CoefTable[p];
            coefFull[NumTaps - 1 - 2 * p] = filterCoefPkg::CoefTable[p];
        end
        coefFull[filterCoefPkg::CenterTap] = filterCoefPkg::CenterCoef;
        repeat (ResetCycles) @(negedge Clk);
        Reset = 1'b0;
        for (int r = 0; r < NumRows; r++)
        begin
            applyRow(Rows[r]);
        end
        for (int i = 0; i < FlushPairs; i++)
        begin
            applyPair(0, 0, 1'b0, 1'b0);
        end
        // Keep Index toggling until every queued result is out
        // Last result is due within Latency cycles, so Latency pairs leave spare time
        draining = 1'b1;
        drainCount = 0;
        while ((expWord0.size() != 0 || expWord1.size() != 0) && drainCount < Latency)
        begin
            drivePair(0, 0);
            drainCount++;
        end
        if (checked0 != keptPairs || checked1 != keptPairs)
            stopOnError("Fewer results came out than kept samples went in");
        else
        begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

// File: filelist.f
src/sampleFormatPkg.sv
src/filterCoefPkg.sv
src/channelInterleaver.sv
src/tapDelayLine.sv
src/symmetricMacSlice.sv
src/halfBandCore.sv
src/roundSaturate.sv
src/dualChannelHalfBand.sv
test/roundSaturate_properties.sv
test/dualChannelHalfBandTb.sv

// File: Makefile
SIM      ?= verilator
TOP      := dualChannelHalfBandTb
FILELIST := filelist.f
FLAGS    := --binary --timing --assert -Wno-fatal -j 0
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
